// ==== hdl/ntps_pkg.sv ====
// NTP/NTS server shared definitions
// Widths, bus structs, register map and clock constants for the
// two NTP clocks, the register block and the key memory
package ntps_pkg;

  // ------------------------------------------------------------
  // Identity and timing constants
  // ------------------------------------------------------------
  localparam logic [31:0] BUILD_INFO = 32'h0003_0102;
  localparam logic [31:0] GIT_HASH   = 32'h9c41_e07b;

  // Fraction increment per clk156 cycle, 2^32 / 156.25 MHz
  localparam logic [31:0] FRAC_STEP = 32'd27;

  localparam int PPS_TIMEOUT = 600;
  localparam int WDOG_W      = $clog2(PPS_TIMEOUT);

  // Length of the time update LED pulse in cycles
  localparam int UPD_STRETCH = 15;
  localparam int STRETCH_W   = $clog2(UPD_STRETCH + 1);

  localparam int KEY_SLOTS = 4;
  localparam int KEY_WORDS = 8;
  localparam int WORD_W    = 32;

  // ------------------------------------------------------------
  // Plain vector types
  // ------------------------------------------------------------
  typedef logic [63:0]                   ntp_time_t;
  typedef logic [31:0]                   ntp_sec_t;
  typedef logic [31:0]                   ntp_frac_t;
  typedef logic [7:0]                    reg_addr_t;
  typedef logic [WORD_W-1:0]             reg_data_t;
  typedef logic [KEY_WORDS*WORD_W-1:0]   key_t;
  typedef logic [$clog2(KEY_SLOTS)-1:0]  key_id_t;
  typedef logic [$clog2(KEY_WORDS)-1:0]  key_word_t;
  typedef logic [KEY_SLOTS-1:0]          key_mask_t;
  typedef logic [WDOG_W-1:0]             wdog_cnt_t;
  typedef logic [STRETCH_W-1:0]          stretch_cnt_t;

  // ------------------------------------------------------------
  // Grouped signals
  // ------------------------------------------------------------
  typedef struct packed {
    logic      we;
    logic      re;
    reg_addr_t addr;
    reg_data_t wdata;
  } reg_req_t;

  // Seconds in the upper half of ntp_time
  typedef struct packed {
    ntp_time_t ntp_time;
    logic      time_upd;
    logic      sync_ok;
  } ntp_status_t;

  typedef struct packed {
    logic      we;
    key_id_t   slot;
    key_word_t word;
    reg_data_t data;
  } key_wr_t;

  // ------------------------------------------------------------
  // Register map
  // ------------------------------------------------------------
  localparam reg_addr_t ADDR_BUILD     = 8'h00;
  localparam reg_addr_t ADDR_HASH      = 8'h01;
  localparam reg_addr_t ADDR_STATUS    = 8'h02;
  localparam reg_addr_t ADDR_SET_A     = 8'h03;
  localparam reg_addr_t ADDR_SET_B     = 8'h04;
  localparam reg_addr_t ADDR_TIME_A_HI = 8'h05;
  localparam reg_addr_t ADDR_TIME_A_LO = 8'h06;
  localparam reg_addr_t ADDR_TIME_B_HI = 8'h07;
  localparam reg_addr_t ADDR_TIME_B_LO = 8'h08;
  localparam reg_addr_t ADDR_KEY_ADDR  = 8'h10;
  localparam reg_addr_t ADDR_KEY_DATA  = 8'h11;
  localparam reg_addr_t ADDR_KEY_VALID = 8'h12;

endpackage

// ==== hdl/ntp_clock.sv ====
// NTP time counter
// Free running 64-bit NTP time, aligned to the next whole second on
// each PPS edge, with a sync watchdog and status LEDs
module ntp_clock (
  input  logic                  clk156,
  input  logic                  arst_n,
  input  logic                  pps,
  input  logic                  set,
  input  ntps_pkg::ntp_sec_t    set_sec,
  output ntps_pkg::ntp_status_t status,
  output logic                  led_sync,
  output logic                  led_pps,
  output logic                  led_upd
);

  logic                   pps_meta;
  logic                   pps_sync;
  logic                   pps_prev;
  logic                   pps_edge;
  logic                   align;
  logic [32:0]            frac_sum;
  ntps_pkg::ntp_sec_t     sec_q;
  ntps_pkg::ntp_frac_t    frac_q;
  logic                   upd_q;
  logic                   sync_q;
  logic                   toggle_q;
  ntps_pkg::wdog_cnt_t    wdog_q;
  ntps_pkg::stretch_cnt_t stretch_q;

  // ------------------------------------------------------------
  // PPS synchronizer and rising edge detect
  // ------------------------------------------------------------
  always_ff @(posedge clk156 or negedge arst_n) begin
    if (!arst_n) begin
      pps_meta <= 1'b0;
      pps_sync <= 1'b0;
      pps_prev <= 1'b0;
    end else begin
      pps_meta <= pps;
      pps_sync <= pps_meta;
      pps_prev <= pps_sync;
    end
  end

  assign pps_edge = pps_sync & ~pps_prev;

  // A set in the same cycle wins over the edge
  assign align    = pps_edge & ~set;
  assign frac_sum = {1'b0, frac_q} + {1'b0, ntps_pkg::FRAC_STEP};

  // ------------------------------------------------------------
  // Time counter
  // ------------------------------------------------------------
  always_ff @(posedge clk156 or negedge arst_n) begin
    if (!arst_n) begin
      sec_q  <= '0;
      frac_q <= '0;
    end else if (set) begin
      sec_q  <= set_sec;
      frac_q <= '0;
    end else if (pps_edge) begin
      sec_q  <= sec_q + 1'b1;
      frac_q <= '0;
    end else begin
      frac_q <= frac_sum[31:0];
      sec_q  <= sec_q + ntps_pkg::ntp_sec_t'(frac_sum[32]);
    end
  end

  // ------------------------------------------------------------
  // Sync watchdog, update pulse and LED state
  // ------------------------------------------------------------
  always_ff @(posedge clk156 or negedge arst_n) begin
    if (!arst_n) begin
      upd_q    <= 1'b0;
      sync_q   <= 1'b0;
      toggle_q <= 1'b0;
      wdog_q   <= '0;
    end else begin
      upd_q <= align;
      if (set) begin
        sync_q <= 1'b0;
        wdog_q <= '0;
      end else if (pps_edge) begin
        sync_q   <= 1'b1;
        toggle_q <= ~toggle_q;
        wdog_q   <= '0;
      end else if (wdog_q == ntps_pkg::wdog_cnt_t'(ntps_pkg::PPS_TIMEOUT - 1)) begin
        // No edge for a full timeout window
        sync_q <= 1'b0;
      end else begin
        wdog_q <= wdog_q + 1'b1;
      end
    end
  end

  // Pulse stretch so the update is visible on an LED
  always_ff @(posedge clk156 or negedge arst_n) begin
    if (!arst_n) begin
      stretch_q <= '0;
    end else if (align) begin
      stretch_q <= ntps_pkg::stretch_cnt_t'(ntps_pkg::UPD_STRETCH);
    end else if (stretch_q != '0) begin
      stretch_q <= stretch_q - 1'b1;
    end
  end

  assign status.ntp_time = {sec_q, frac_q};
  assign status.time_upd = upd_q;
  assign status.sync_ok  = sync_q;

  assign led_sync = sync_q;
  assign led_pps  = toggle_q;
  assign led_upd  = (stretch_q != '0);

endmodule

// ==== hdl/ntps_regs.sv ====
// Register block for the NTP/NTS top level
// Decodes the strobe bus, loads the clocks, snapshots the time
// fractions and streams key words into the key memory
module ntps_regs (
  input  logic                  clk156,
  input  logic                  arst_n,
  input  ntps_pkg::reg_req_t    req,
  input  ntps_pkg::ntp_status_t ntp_a,
  input  ntps_pkg::ntp_status_t ntp_b,
  input  ntps_pkg::key_mask_t   key_valid,
  output ntps_pkg::reg_data_t   rdata,
  output logic                  rvalid,
  output logic                  set_a,
  output logic                  set_b,
  output ntps_pkg::ntp_sec_t    set_sec,
  output ntps_pkg::key_wr_t     key_wr,
  output logic                  key_valid_wr
);

  logic                 wr_key_addr;
  logic                 wr_key_data;
  logic                 rd_time_a_hi;
  logic                 rd_time_b_hi;
  ntps_pkg::reg_data_t  rd_next;
  ntps_pkg::reg_data_t  rdata_q;
  logic                 rvalid_q;
  ntps_pkg::ntp_frac_t  snap_a_q;
  ntps_pkg::ntp_frac_t  snap_b_q;
  ntps_pkg::key_id_t    key_slot_q;
  ntps_pkg::key_word_t  key_word_q;

  // ------------------------------------------------------------
  // Write decode
  // ------------------------------------------------------------
  // Load pulses leave in the strobe cycle so the write lands on the
  // next clock edge
  assign set_a        = req.we && (req.addr == ntps_pkg::ADDR_SET_A);
  assign set_b        = req.we && (req.addr == ntps_pkg::ADDR_SET_B);
  assign set_sec      = req.wdata;
  assign key_valid_wr = req.we && (req.addr == ntps_pkg::ADDR_KEY_VALID);
  assign wr_key_addr  = req.we && (req.addr == ntps_pkg::ADDR_KEY_ADDR);
  assign wr_key_data  = req.we && (req.addr == ntps_pkg::ADDR_KEY_DATA);

  assign key_wr.we   = wr_key_data;
  assign key_wr.slot = key_slot_q;
  assign key_wr.word = key_word_q;
  assign key_wr.data = req.wdata;

  // Key pointer with auto increment on each data word
  always_ff @(posedge clk156 or negedge arst_n) begin
    if (!arst_n) begin
      key_slot_q <= '0;
      key_word_q <= '0;
    end else if (wr_key_addr) begin
      key_slot_q <= req.wdata[4:3];
      key_word_q <= req.wdata[2:0];
    end else if (wr_key_data) begin
      key_word_q <= key_word_q + 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Time snapshots
  // ------------------------------------------------------------
  assign rd_time_a_hi = req.re && (req.addr == ntps_pkg::ADDR_TIME_A_HI);
  assign rd_time_b_hi = req.re && (req.addr == ntps_pkg::ADDR_TIME_B_HI);

  // Fraction captured together with the seconds read
  always_ff @(posedge clk156 or negedge arst_n) begin
    if (!arst_n) begin
      snap_a_q <= '0;
      snap_b_q <= '0;
    end else begin
      if (rd_time_a_hi) begin
        snap_a_q <= ntp_a.ntp_time[31:0];
      end
      if (rd_time_b_hi) begin
        snap_b_q <= ntp_b.ntp_time[31:0];
      end
    end
  end

  // ------------------------------------------------------------
  // Read decode
  // ------------------------------------------------------------
  always_comb begin
    rd_next = '0;
    case (req.addr)
      ntps_pkg::ADDR_BUILD:     rd_next = ntps_pkg::BUILD_INFO;
      ntps_pkg::ADDR_HASH:      rd_next = ntps_pkg::GIT_HASH;
      ntps_pkg::ADDR_STATUS:    rd_next = {30'b0, ntp_b.sync_ok, ntp_a.sync_ok};
      ntps_pkg::ADDR_TIME_A_HI: rd_next = ntp_a.ntp_time[63:32];
      ntps_pkg::ADDR_TIME_A_LO: rd_next = snap_a_q;
      ntps_pkg::ADDR_TIME_B_HI: rd_next = ntp_b.ntp_time[63:32];
      ntps_pkg::ADDR_TIME_B_LO: rd_next = snap_b_q;
      ntps_pkg::ADDR_KEY_ADDR:  rd_next = {27'b0, key_slot_q, key_word_q};
      ntps_pkg::ADDR_KEY_VALID: rd_next = {28'b0, key_valid};
      default:                  rd_next = '0;
    endcase
  end

  always_ff @(posedge clk156) begin
    if (req.re) begin
      rdata_q <= rd_next;
    end
  end

  always_ff @(posedge clk156 or negedge arst_n) begin
    if (!arst_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req.re;
    end
  end

  assign rdata  = rdata_q;
  assign rvalid = rvalid_q;

endmodule

// ==== hdl/ntps_keymem.sv ====
// NTS key memory
// Holds the key slots as 32-bit words with a valid mask and answers
// key lookups from the network side one cycle after the request
module ntps_keymem (
  input  logic                clk156,
  input  logic                arst_n,
  input  ntps_pkg::key_wr_t   key_wr,
  input  logic                key_valid_wr,
  input  ntps_pkg::key_mask_t valid_data,
  input  logic                key_req,
  input  ntps_pkg::key_id_t   key_id,
  output ntps_pkg::key_mask_t key_valid,
  output logic                key_ack,
  output logic                key_hit,
  output ntps_pkg::key_t      key
);

  ntps_pkg::reg_data_t mem_q [ntps_pkg::KEY_SLOTS][ntps_pkg::KEY_WORDS];
  ntps_pkg::key_mask_t valid_q;
  ntps_pkg::key_t      key_sel;
  ntps_pkg::key_t      key_q;
  logic                ack_q;
  logic                hit_q;

  // ------------------------------------------------------------
  // Key storage and valid mask
  // ------------------------------------------------------------
  always_ff @(posedge clk156) begin
    if (key_wr.we) begin
      mem_q[key_wr.slot][key_wr.word] <= key_wr.data;
    end
  end

  always_ff @(posedge clk156 or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
    end else if (key_valid_wr) begin
      valid_q <= valid_data;
    end
  end

  // ------------------------------------------------------------
  // Lookup
  // ------------------------------------------------------------
  // Word 0 sits in the low bits of the key
  always_comb begin
    key_sel = '0;
    for (int w = 0; w < ntps_pkg::KEY_WORDS; w++) begin
      key_sel[w*ntps_pkg::WORD_W +: ntps_pkg::WORD_W] = mem_q[key_id][w];
    end
  end

  always_ff @(posedge clk156 or negedge arst_n) begin
    if (!arst_n) begin
      ack_q <= 1'b0;
      hit_q <= 1'b0;
    end else begin
      ack_q <= key_req;
      hit_q <= key_req && valid_q[key_id];
    end
  end

  // Invalid slots return an all zero key
  always_ff @(posedge clk156) begin
    if (key_req) begin
      key_q <= valid_q[key_id] ? key_sel : '0;
    end
  end

  assign key_valid = valid_q;
  assign key_ack   = ack_q;
  assign key_hit   = hit_q;
  assign key       = key_q;

endmodule

// ==== hdl/ntps_top.sv ====
// NTP/NTS server top level
// Two PPS aligned NTP clocks, the register block, the key memory
// and the debug LED map, all on clk156
module ntps_top (
  input  logic                  clk156,
  input  logic                  arst_n,
  input  ntps_pkg::reg_req_t    reg_req,
  output ntps_pkg::reg_data_t   rdata,
  output logic                  rvalid,
  input  logic                  pps_a,
  input  logic                  pps_b,
  input  logic                  key_req,
  input  ntps_pkg::key_id_t     key_id,
  output logic                  key_ack,
  output logic                  key_hit,
  output ntps_pkg::key_t        key,
  output ntps_pkg::ntp_status_t ntp_a,
  output ntps_pkg::ntp_status_t ntp_b,
  output logic [7:0]            led
);

  logic                set_a;
  logic                set_b;
  ntps_pkg::ntp_sec_t  set_sec;
  ntps_pkg::key_wr_t   key_wr;
  logic                key_valid_wr;
  ntps_pkg::key_mask_t key_valid;
  logic                led_sync_a;
  logic                led_pps_a;
  logic                led_upd_a;
  logic                led_sync_b;
  logic                led_pps_b;
  logic                led_upd_b;

  // ------------------------------------------------------------
  // NTP clocks
  // ------------------------------------------------------------
  ntp_clock u_clock_a (
    .clk156   (clk156),
    .arst_n   (arst_n),
    .pps      (pps_a),
    .set      (set_a),
    .set_sec  (set_sec),
    .status   (ntp_a),
    .led_sync (led_sync_a),
    .led_pps  (led_pps_a),
    .led_upd  (led_upd_a)
  );

  ntp_clock u_clock_b (
    .clk156   (clk156),
    .arst_n   (arst_n),
    .pps      (pps_b),
    .set      (set_b),
    .set_sec  (set_sec),
    .status   (ntp_b),
    .led_sync (led_sync_b),
    .led_pps  (led_pps_b),
    .led_upd  (led_upd_b)
  );

  // ------------------------------------------------------------
  // Register block and key memory
  // ------------------------------------------------------------
  ntps_regs u_regs (
    .clk156       (clk156),
    .arst_n       (arst_n),
    .req          (reg_req),
    .ntp_a        (ntp_a),
    .ntp_b        (ntp_b),
    .key_valid    (key_valid),
    .rdata        (rdata),
    .rvalid       (rvalid),
    .set_a        (set_a),
    .set_b        (set_b),
    .set_sec      (set_sec),
    .key_wr       (key_wr),
    .key_valid_wr (key_valid_wr)
  );

  ntps_keymem u_keymem (
    .clk156       (clk156),
    .arst_n       (arst_n),
    .key_wr       (key_wr),
    .key_valid_wr (key_valid_wr),
    .valid_data   (reg_req.wdata[ntps_pkg::KEY_SLOTS-1:0]),
    .key_req      (key_req),
    .key_id       (key_id),
    .key_valid    (key_valid),
    .key_ack      (key_ack),
    .key_hit      (key_hit),
    .key          (key)
  );

  // Debug LEDs, bits 3 and 7 unused
  assign led = {1'b0, led_upd_b, led_pps_b, led_sync_b,
                1'b0, led_upd_a, led_pps_a, led_sync_a};

endmodule

// ==== bench/ntps_assert.sv ====
// Protocol checks for the NTP/NTS top level
// Read and key acknowledges come one cycle after their strobe and
// time update pulses last a single cycle
module ntps_assert (
  input logic clk156,
  input logic arst_n,
  input logic re,
  input logic rvalid,
  input logic key_req,
  input logic key_ack,
  input logic upd_a,
  input logic upd_b
);
  timeunit 1ns;
  timeprecision 100ps;

  a_key_ack: assert property (@(posedge clk156) disable iff (!arst_n)
    key_ack == $past(key_req)) else $error("key_ack does not follow key_req by one cycle");

  a_rvalid: assert property (@(posedge clk156) disable iff (!arst_n)
    rvalid == $past(re)) else $error("rvalid does not follow re by one cycle");

  a_upd_a: assert property (@(posedge clk156) disable iff (!arst_n)
    upd_a |=> !upd_a) else $error("time_upd of clock A high for two cycles");

  a_upd_b: assert property (@(posedge clk156) disable iff (!arst_n)
    upd_b |=> !upd_b) else $error("time_upd of clock B high for two cycles");

endmodule

bind ntps_top ntps_assert u_assert (
  .clk156  (clk156),
  .arst_n  (arst_n),
  .re      (reg_req.re),
  .rvalid  (rvalid),
  .key_req (key_req),
  .key_ack (key_ack),
  .upd_a   (ntp_a.time_upd),
  .upd_b   (ntp_b.time_upd)
);

// ==== bench/ntps_tb.sv ====
// Directed testbench for the NTP/NTS top level
// Drives the strobe bus, the PPS pins and the key lookup port and
// checks identity, PPS alignment, sync loss, snapshots and keys
module ntps_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_HALF     = 10;
  localparam int RESET_CYCLES = 5;
  localparam int WAIT_LIMIT   = 16;
  // The sync loss wait of one timeout window dominates the run
  localparam int WDOG_CYCLES  = 20 * ntps_pkg::PPS_TIMEOUT;

  localparam ntps_pkg::ntp_sec_t SEC_A = 32'he5a1_0000;
  localparam ntps_pkg::ntp_sec_t SEC_B = 32'h3b7c_1200;
  localparam ntps_pkg::ntp_sec_t SEC_C = 32'h0000_8000;
  localparam ntps_pkg::ntp_sec_t SEC_D = 32'h7fff_fff0;

  logic                  clk156;
  logic                  arst_n;
  ntps_pkg::reg_req_t    reg_req;
  ntps_pkg::reg_data_t   rdata;
  logic                  rvalid;
  logic                  pps_a;
  logic                  pps_b;
  logic                  key_req;
  ntps_pkg::key_id_t     key_id;
  logic                  key_ack;
  logic                  key_hit;
  ntps_pkg::key_t        key;
  ntps_pkg::ntp_status_t ntp_a;
  ntps_pkg::ntp_status_t ntp_b;
  logic [7:0]            led;
  integer                seed;

  ntps_top i_ntps_top (
    .clk156  (clk156),
    .arst_n  (arst_n),
    .reg_req (reg_req),
    .rdata   (rdata),
    .rvalid  (rvalid),
    .pps_a   (pps_a),
    .pps_b   (pps_b),
    .key_req (key_req),
    .key_id  (key_id),
    .key_ack (key_ack),
    .key_hit (key_hit),
    .key     (key),
    .ntp_a   (ntp_a),
    .ntp_b   (ntp_b),
    .led     (led)
  );

  initial begin
    clk156 = 1'b0;
    forever #CLK_HALF clk156 = ~clk156;
  end

  initial begin
    repeat (WDOG_CYCLES) @(posedge clk156);
    abort_run("Watchdog expired before the tests finished");
  end

  // ------------------------------------------------------------
  // Error reporting and compare tasks
  // ------------------------------------------------------------
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_data(input ntps_pkg::reg_data_t got, input ntps_pkg::reg_data_t exp,
                            input string name);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_time(input ntps_pkg::ntp_time_t got, input ntps_pkg::ntp_time_t exp,
                            input string name);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s: got 0x%016h expected 0x%016h", name, got, exp));
    end
  endtask

  task automatic check_key(input ntps_pkg::key_t got, input ntps_pkg::key_t exp,
                           input string name);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s: got 0x%064h expected 0x%064h", name, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic ntps_pkg::ntp_time_t whole_second(input ntps_pkg::ntp_sec_t sec);
    return {sec, 32'h0};
  endfunction

  // ------------------------------------------------------------
  // Bus, PPS and key port drivers
  // ------------------------------------------------------------
  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk156);
  endtask

  task automatic reg_write(input ntps_pkg::reg_addr_t addr, input ntps_pkg::reg_data_t data);
    @(negedge clk156);
    reg_req.we    = 1'b1;
    reg_req.re    = 1'b0;
    reg_req.addr  = addr;
    reg_req.wdata = data;
    @(negedge clk156);
    reg_req = '0;
  endtask

  task automatic reg_read(input ntps_pkg::reg_addr_t addr, output ntps_pkg::reg_data_t data);
    int n;
    @(negedge clk156);
    reg_req.we    = 1'b0;
    reg_req.re    = 1'b1;
    reg_req.addr  = addr;
    reg_req.wdata = '0;
    @(negedge clk156);
    reg_req = '0;
    n = 0;
    while (!rvalid) begin
      if (n == WAIT_LIMIT) abort_run($sformatf("No rvalid after a read of 0x%02h", addr));
      @(negedge clk156);
      n++;
    end
    data = rdata;
  endtask

  // Raise one PPS pin and return the clock status at its update pulse
  task automatic pps_align(input logic on_b, output ntps_pkg::ntp_status_t st);
    int n;
    @(negedge clk156);
    if (on_b) begin
      pps_b = 1'b1;
    end else begin
      pps_a = 1'b1;
    end
    n = 0;
    st = on_b ? ntp_b : ntp_a;
    while (!st.time_upd) begin
      if (n == WAIT_LIMIT) abort_run("PPS rising edge gave no time update");
      @(negedge clk156);
      n++;
      st = on_b ? ntp_b : ntp_a;
    end
    check_data(ntps_pkg::reg_data_t'(n), 32'd3, "pps to time_upd cycles");
    check_bit(on_b ? led[6] : led[2], 1'b1, "led time_upd");
    @(negedge clk156);
    pps_a = 1'b0;
    pps_b = 1'b0;
    idle_cycles(4);
  endtask

  task automatic key_lookup(input ntps_pkg::key_id_t id, output logic hit,
                            output ntps_pkg::key_t k);
    int n;
    @(negedge clk156);
    key_req = 1'b1;
    key_id  = id;
    @(negedge clk156);
    key_req = 1'b0;
    n = 0;
    while (!key_ack) begin
      if (n == WAIT_LIMIT) abort_run("No key_ack after a key request");
      @(negedge clk156);
      n++;
    end
    check_data(ntps_pkg::reg_data_t'(n), 32'd0, "key_ack extra delay");
    hit = key_hit;
    k   = key;
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  task automatic identity_and_decode();
    ntps_pkg::reg_data_t rd;
    check_bit(rvalid, 1'b0, "rvalid");
    check_bit(key_ack, 1'b0, "key_ack");
    check_data({24'b0, led}, 32'h0, "led");
    check_time(ntp_a.ntp_time, 64'h0, "ntp_a.ntp_time");
    check_time(ntp_b.ntp_time, 64'h0, "ntp_b.ntp_time");
    reg_read(ntps_pkg::ADDR_BUILD, rd);
    check_data(rd, ntps_pkg::BUILD_INFO, "build");
    reg_read(ntps_pkg::ADDR_HASH, rd);
    check_data(rd, ntps_pkg::GIT_HASH, "hash");
    reg_read(8'h3c, rd);
    check_data(rd, 32'h0, "unmapped 0x3c");
    reg_read(ntps_pkg::ADDR_STATUS, rd);
    check_data(rd, 32'h0, "status");
    reg_read(ntps_pkg::ADDR_KEY_VALID, rd);
    check_data(rd, 32'h0, "key_valid");
  endtask

  task automatic set_and_align();
    ntps_pkg::ntp_status_t st;
    ntps_pkg::reg_data_t   rd;
    reg_write(ntps_pkg::ADDR_SET_A, SEC_A);
    check_time(ntp_a.ntp_time, whole_second(SEC_A), "ntp_a.ntp_time after set");
    check_bit(ntp_a.sync_ok, 1'b0, "ntp_a.sync_ok after set");
    pps_align(1'b0, st);
    check_time(st.ntp_time, whole_second(SEC_A + 32'd1), "ntp_a.ntp_time at pps");
    check_bit(st.sync_ok, 1'b1, "ntp_a.sync_ok at pps");
    reg_read(ntps_pkg::ADDR_STATUS, rd);
    check_data(rd, 32'h1, "status");
    check_bit(led[0], 1'b1, "led[0]");
    check_bit(led[1], 1'b1, "led[1]");
    pps_align(1'b0, st);
    check_time(st.ntp_time, whole_second(SEC_A + 32'd2), "ntp_a.ntp_time at 2nd pps");
    check_bit(led[1], 1'b0, "led[1]");
  endtask

  task automatic clocks_independent();
    ntps_pkg::ntp_status_t st;
    ntps_pkg::ntp_time_t   a_before;
    ntps_pkg::ntp_sec_t    a_exp;
    ntps_pkg::reg_data_t   rd;
    a_before = ntp_a.ntp_time;
    reg_write(ntps_pkg::ADDR_SET_B, SEC_B);
    check_time(ntp_b.ntp_time, whole_second(SEC_B), "ntp_b.ntp_time after set");
    pps_align(1'b1, st);
    check_time(st.ntp_time, whole_second(SEC_B + 32'd1), "ntp_b.ntp_time at pps");
    check_bit(st.sync_ok, 1'b1, "ntp_b.sync_ok at pps");
    // A only moves on a fraction carry
    a_exp = a_before[63:32];
    if (ntp_a.ntp_time[31:0] < a_before[31:0]) a_exp = a_exp + 32'd1;
    check_data(ntp_a.ntp_time[63:32], a_exp, "ntp_a seconds");
    reg_read(ntps_pkg::ADDR_STATUS, rd);
    check_data(rd, 32'h3, "status");
    check_bit(led[4], 1'b1, "led[4]");
    check_bit(led[5], 1'b1, "led[5]");
  endtask

  task automatic sync_loss();
    ntps_pkg::ntp_status_t st;
    ntps_pkg::reg_data_t   rd;
    idle_cycles(ntps_pkg::PPS_TIMEOUT + 8);
    reg_read(ntps_pkg::ADDR_STATUS, rd);
    check_data(rd, 32'h0, "status after timeout");
    check_bit(led[0], 1'b0, "led[0]");
    check_bit(led[2], 1'b0, "led[2]");
    check_bit(led[4], 1'b0, "led[4]");
    check_bit(led[6], 1'b0, "led[6]");
    pps_align(1'b0, st);
    check_bit(st.sync_ok, 1'b1, "ntp_a.sync_ok at pps");
    reg_write(ntps_pkg::ADDR_SET_A, SEC_C);
    check_bit(ntp_a.sync_ok, 1'b0, "ntp_a.sync_ok after set");
    reg_read(ntps_pkg::ADDR_STATUS, rd);
    check_bit(rd[0], 1'b0, "status sync_a");
  endtask

  task automatic time_snapshot();
    ntps_pkg::reg_data_t rd;
    ntps_pkg::reg_data_t frac;
    reg_write(ntps_pkg::ADDR_SET_A, SEC_D);
    reg_read(ntps_pkg::ADDR_TIME_A_HI, rd);
    check_data(rd, SEC_D, "time_a_hi");
    reg_read(ntps_pkg::ADDR_TIME_A_LO, frac);
    check_data(frac % ntps_pkg::FRAC_STEP, 32'h0, "time_a_lo mod frac_step");
    if (frac == 32'h0) abort_run("Snapshot fraction is zero although the clock ran");
    reg_read(ntps_pkg::ADDR_TIME_A_LO, rd);
    check_data(rd, frac, "time_a_lo repeat");
  endtask

  task automatic key_load_lookup();
    ntps_pkg::reg_data_t word;
    ntps_pkg::reg_data_t rd;
    ntps_pkg::key_t      exp_key;
    ntps_pkg::key_t      k;
    logic                hit;
    exp_key = '0;
    reg_write(ntps_pkg::ADDR_KEY_ADDR, {27'd0, 2'd2, 3'd0});
    for (int w = 0; w < ntps_pkg::KEY_WORDS; w++) begin
      word = $random(seed);
      exp_key[w*ntps_pkg::WORD_W +: ntps_pkg::WORD_W] = word;
      reg_write(ntps_pkg::ADDR_KEY_DATA, word);
    end
    reg_write(ntps_pkg::ADDR_KEY_VALID, 32'h4);
    // Word pointer wrapped after eight words
    reg_read(ntps_pkg::ADDR_KEY_ADDR, rd);
    check_data(rd, 32'h10, "key_addr");
    key_lookup(2'd2, hit, k);
    check_bit(hit, 1'b1, "key_hit slot 2");
    check_key(k, exp_key, "key slot 2");
    key_lookup(2'd1, hit, k);
    check_bit(hit, 1'b0, "key_hit slot 1");
    check_key(k, '0, "key slot 1");
    reg_read(ntps_pkg::ADDR_KEY_VALID, rd);
    check_data(rd, 32'h4, "key_valid");
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    seed    = 84271;
    arst_n  = 1'b0;
    reg_req = '0;
    pps_a   = 1'b0;
    pps_b   = 1'b0;
    key_req = 1'b0;
    key_id  = '0;
    repeat (RESET_CYCLES) @(negedge clk156);
    arst_n = 1'b1;
    // Reset state is checked before the first clock edge out of reset
    identity_and_decode();
    set_and_align();
    clocks_independent();
    sync_loss();
    time_snapshot();
    key_load_lookup();
    $display("All tests passed");
    $finish;
  end

endmodule

// ==== src.f ====
hdl/ntps_pkg.sv
hdl/ntp_clock.sv
hdl/ntps_regs.sv
hdl/ntps_keymem.sv
hdl/ntps_top.sv
bench/ntps_assert.sv
bench/ntps_tb.sv

// ==== Makefile ====
# Verilator build and run for the NTP/NTS testbench

VERILATOR ?= verilator
TOP       ?= ntps_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
